/* common/soc_pkg.sv */
// Shared definitions for the SoC: bus widths, address map, register
// offsets, FSM state types and the byte-strobe merge helper.
// Compile first; modules import it inside their bodies.
package soc_pkg;

  ////////////////////////////////////////
  // Bus geometry
  ////////////////////////////////////////
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;

  // Slave select on address bits 31:28
  localparam logic [3:0] REGION_MEM = 4'h0;
  localparam logic [3:0] REGION_DMA = 4'h1;
  localparam logic [3:0] REGION_KEY = 4'h2;

  localparam int MEM_WORDS = 256;
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);

  ////////////////////////////////////////
  // Register offsets
  ////////////////////////////////////////
  localparam logic [3:0] DMA_SRC  = 4'h0;
  localparam logic [3:0] DMA_DST  = 4'h4;
  localparam logic [3:0] DMA_LEN  = 4'h8;
  localparam logic [3:0] DMA_CTRL = 4'hC;

  localparam logic [3:0] KEY_DATA  = 4'h0;
  localparam logic [3:0] KEY_COUNT = 4'h4;
  localparam int         KEY_DEPTH = 8;
  localparam int         KEY_PTR_W = $clog2(KEY_DEPTH);

  // Returned on reads of an unmapped region
  localparam logic [DATA_W-1:0] BUS_DEFAULT_DATA = '0;

  typedef enum logic [1:0] {DMA_IDLE, DMA_READ, DMA_WRITE, DMA_DONE} dma_state_t;
  typedef enum logic [1:0] {GNT_NONE, GNT_CPU, GNT_DMA} grant_t;

  // Replace the bytes of old_w selected by strb with those of new_w
  function automatic logic [DATA_W-1:0] apply_strb(input logic [DATA_W-1:0] old_w,
                                                   input logic [DATA_W-1:0] new_w,
                                                   input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old_w;
    for (int b = 0; b < STRB_W; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

/* hdl/wish_bus.sv */
// Shared bus with two masters (CPU port and DMA) and three slaves.
// Registered round-robin grant, decode on address bits 31:28, and a
// bus-generated acknowledge for unmapped regions.
`timescale 1ns/1ps
module wish_bus (
  input  logic                         clk,
  input  logic                         rst_i,
  // CPU master
  input  logic                         m_cpu_cyc_i,
  input  logic                         m_cpu_we_i,
  input  logic [soc_pkg::STRB_W-1:0]   m_cpu_strb_i,
  input  logic [soc_pkg::ADDR_W-1:0]   m_cpu_addr_i,
  input  logic [soc_pkg::DATA_W-1:0]   m_cpu_data_i,
  output logic                         m_cpu_ack_o,
  output logic [soc_pkg::DATA_W-1:0]   m_cpu_data_o,
  // DMA master
  input  logic                         m_dma_cyc_i,
  input  logic                         m_dma_we_i,
  input  logic [soc_pkg::STRB_W-1:0]   m_dma_strb_i,
  input  logic [soc_pkg::ADDR_W-1:0]   m_dma_addr_i,
  input  logic [soc_pkg::DATA_W-1:0]   m_dma_data_i,
  output logic                         m_dma_ack_o,
  output logic [soc_pkg::DATA_W-1:0]   m_dma_data_o,
  // Memory slave
  output logic                         s_mem_cyc_o,
  output logic                         s_mem_we_o,
  output logic [soc_pkg::STRB_W-1:0]   s_mem_strb_o,
  output logic [soc_pkg::ADDR_W-1:0]   s_mem_addr_o,
  output logic [soc_pkg::DATA_W-1:0]   s_mem_data_o,
  input  logic                         s_mem_ack_i,
  input  logic [soc_pkg::DATA_W-1:0]   s_mem_data_i,
  // DMA register slave
  output logic                         s_dma_cyc_o,
  output logic                         s_dma_we_o,
  output logic [soc_pkg::STRB_W-1:0]   s_dma_strb_o,
  output logic [soc_pkg::ADDR_W-1:0]   s_dma_addr_o,
  output logic [soc_pkg::DATA_W-1:0]   s_dma_data_o,
  input  logic                         s_dma_ack_i,
  input  logic [soc_pkg::DATA_W-1:0]   s_dma_data_i,
  // Keyboard slave
  output logic                         s_key_cyc_o,
  output logic                         s_key_we_o,
  output logic [soc_pkg::STRB_W-1:0]   s_key_strb_o,
  output logic [soc_pkg::ADDR_W-1:0]   s_key_addr_o,
  output logic [soc_pkg::DATA_W-1:0]   s_key_data_o,
  input  logic                         s_key_ack_i,
  input  logic [soc_pkg::DATA_W-1:0]   s_key_data_i
);
  import soc_pkg::*;

  grant_t            grant_q;
  logic              last_cpu_q;
  logic              use_dma;
  logic              sel_cyc;
  logic              sel_we;
  logic [STRB_W-1:0] sel_strb;
  logic [ADDR_W-1:0] sel_addr;
  logic [DATA_W-1:0] sel_data;
  logic [3:0]        region;
  logic              unmapped;
  logic              err_ack_q;
  logic              rsp_ack;
  logic [DATA_W-1:0] rsp_data;

  ////////////////////////////////////////
  // Arbitration
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      grant_q    <= GNT_NONE;
      last_cpu_q <= 1'b0;
    end else begin
      case (grant_q)
        GNT_NONE: begin
          // CPU yields to a waiting DMA if it had the last turn
          if (m_cpu_cyc_i && (!m_dma_cyc_i || !last_cpu_q)) begin
            grant_q    <= GNT_CPU;
            last_cpu_q <= 1'b1;
          end else if (m_dma_cyc_i) begin
            grant_q    <= GNT_DMA;
            last_cpu_q <= 1'b0;
          end
        end
        GNT_CPU: if (!m_cpu_cyc_i || m_cpu_ack_o) grant_q <= GNT_NONE;
        GNT_DMA: if (!m_dma_cyc_i || m_dma_ack_o) grant_q <= GNT_NONE;
        default: grant_q <= GNT_NONE;
      endcase
    end
  end

  // Granted master request
  assign use_dma  = (grant_q == GNT_DMA);
  assign sel_cyc  = ((grant_q == GNT_CPU) && m_cpu_cyc_i) || (use_dma && m_dma_cyc_i);
  assign sel_we   = use_dma ? m_dma_we_i   : m_cpu_we_i;
  assign sel_strb = use_dma ? m_dma_strb_i : m_cpu_strb_i;
  assign sel_addr = use_dma ? m_dma_addr_i : m_cpu_addr_i;
  assign sel_data = use_dma ? m_dma_data_i : m_cpu_data_i;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////
  assign region   = sel_addr[ADDR_W-1 -: 4];
  assign unmapped = (region != REGION_MEM) && (region != REGION_DMA) && (region != REGION_KEY);

  assign s_mem_cyc_o = sel_cyc && (region == REGION_MEM);
  assign s_dma_cyc_o = sel_cyc && (region == REGION_DMA);
  assign s_key_cyc_o = sel_cyc && (region == REGION_KEY);

  assign {s_mem_we_o, s_mem_strb_o, s_mem_addr_o, s_mem_data_o} =
    {sel_we, sel_strb, sel_addr, sel_data};
  assign {s_dma_we_o, s_dma_strb_o, s_dma_addr_o, s_dma_data_o} =
    {sel_we, sel_strb, sel_addr, sel_data};
  assign {s_key_we_o, s_key_strb_o, s_key_addr_o, s_key_data_o} =
    {sel_we, sel_strb, sel_addr, sel_data};

  // Bus answers unmapped accesses itself
  always_ff @(posedge clk) begin
    if (rst_i) begin
      err_ack_q <= 1'b0;
    end else begin
      err_ack_q <= sel_cyc && unmapped && !err_ack_q;
    end
  end

  // Response back to the granted master only
  always_comb begin
    case (region)
      REGION_MEM: begin
        rsp_ack  = s_mem_ack_i;
        rsp_data = s_mem_data_i;
      end
      REGION_DMA: begin
        rsp_ack  = s_dma_ack_i;
        rsp_data = s_dma_data_i;
      end
      REGION_KEY: begin
        rsp_ack  = s_key_ack_i;
        rsp_data = s_key_data_i;
      end
      default: begin
        rsp_ack  = err_ack_q;
        rsp_data = BUS_DEFAULT_DATA;
      end
    endcase
  end

  assign m_cpu_ack_o  = (grant_q == GNT_CPU) && rsp_ack;
  assign m_cpu_data_o = (grant_q == GNT_CPU) ? rsp_data : BUS_DEFAULT_DATA;
  assign m_dma_ack_o  = use_dma && rsp_ack;
  assign m_dma_data_o = use_dma ? rsp_data : BUS_DEFAULT_DATA;

endmodule

/* hdl/main_mem.sv */
// Main memory slave: MEM_WORDS words indexed by address bits 9:2.
// Byte-strobed writes, registered read data, ack one cycle after cyc.
`timescale 1ns/1ps
module main_mem (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       s_cyc_i,
  input  logic                       s_we_i,
  input  logic [soc_pkg::STRB_W-1:0] s_strb_i,
  input  logic [soc_pkg::ADDR_W-1:0] s_addr_i,
  input  logic [soc_pkg::DATA_W-1:0] s_data_i,
  output logic                       s_ack_o,
  output logic [soc_pkg::DATA_W-1:0] s_data_o
);
  import soc_pkg::*;

  logic [DATA_W-1:0]    mem [MEM_WORDS];
  logic [MEM_IDX_W-1:0] idx;
  logic                 access;
  logic                 ack_q;
  logic [DATA_W-1:0]    rdata_q;

  assign idx    = s_addr_i[MEM_IDX_W+1:2];
  // Cycle after an ack is ignored so a held cyc is not served twice
  assign access = s_cyc_i && !ack_q;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  // Storage and read data
  always_ff @(posedge clk) begin
    if (access) begin
      if (s_we_i) begin
        mem[idx] <= apply_strb(mem[idx], s_data_i, s_strb_i);
      end
      rdata_q <= mem[idx];
    end
  end

  assign s_ack_o  = ack_q;
  assign s_data_o = rdata_q;

endmodule

/* keyboard/keyboard.sv */
// Keyboard slave: scan codes arrive on a valid/ready input into an
// 8-entry FIFO. Reading KEY_DATA pops one code, KEY_COUNT gives the level.
`timescale 1ns/1ps
module keyboard (
  input  logic                       clk,
  input  logic                       rst_i,
  input  logic                       key_valid_i,
  input  logic [7:0]                 key_data_i,
  output logic                       key_ready_o,
  input  logic                       s_cyc_i,
  input  logic                       s_we_i,
  input  logic [soc_pkg::STRB_W-1:0] s_strb_i,
  input  logic [soc_pkg::ADDR_W-1:0] s_addr_i,
  input  logic [soc_pkg::DATA_W-1:0] s_data_i,
  output logic                       s_ack_o,
  output logic [soc_pkg::DATA_W-1:0] s_data_o
);
  import soc_pkg::*;

  logic [7:0]           fifo_q [KEY_DEPTH];
  logic [KEY_PTR_W-1:0] wr_ptr_q;
  logic [KEY_PTR_W-1:0] rd_ptr_q;
  logic [KEY_PTR_W:0]   count_q;
  logic                 empty;
  logic                 push;
  logic                 pop;
  logic                 access;
  logic                 ack_q;
  logic [DATA_W-1:0]    rdata_q;

  assign empty       = (count_q == '0);
  assign key_ready_o = (count_q != KEY_DEPTH);
  assign push        = key_valid_i && key_ready_o;
  assign access      = s_cyc_i && !ack_q;
  assign pop         = access && !s_we_i && (s_addr_i[3:0] == KEY_DATA) && !empty;

  ////////////////////////////////////////
  // FIFO pointers and level
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      ack_q    <= 1'b0;
    end else begin
      ack_q <= access;
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) fifo_q[wr_ptr_q] <= key_data_i;
  end

  // Register reads; writes only get an ack
  always_ff @(posedge clk) begin
    if (access) begin
      case (s_addr_i[3:0])
        KEY_DATA:  rdata_q <= empty ? '0 : {{(DATA_W-9){1'b0}}, 1'b1, fifo_q[rd_ptr_q]};
        KEY_COUNT: rdata_q <= {{(DATA_W-KEY_PTR_W-1){1'b0}}, count_q};
        default:   rdata_q <= '0;
      endcase
    end
  end

  assign s_ack_o  = ack_q;
  assign s_data_o = rdata_q;

endmodule

/* disk/dma_ctrl.sv */
// DMA engine: register slave for SRC, DST, LEN and CTRL, plus a bus
// master that copies LEN words from SRC to DST one read/write pair at a
// time. irq_o rises after the last write and is cleared through CTRL bit 1.
`timescale 1ns/1ps
module dma_ctrl (
  input  logic                       clk,
  input  logic                       rst_i,
  // Register slave
  input  logic                       s_cyc_i,
  input  logic                       s_we_i,
  input  logic [soc_pkg::STRB_W-1:0] s_strb_i,
  input  logic [soc_pkg::ADDR_W-1:0] s_addr_i,
  input  logic [soc_pkg::DATA_W-1:0] s_data_i,
  output logic                       s_ack_o,
  output logic [soc_pkg::DATA_W-1:0] s_data_o,
  // Copy master
  output logic                       m_cyc_o,
  output logic                       m_we_o,
  output logic [soc_pkg::STRB_W-1:0] m_strb_o,
  output logic [soc_pkg::ADDR_W-1:0] m_addr_o,
  output logic [soc_pkg::DATA_W-1:0] m_data_o,
  input  logic                       m_ack_i,
  input  logic [soc_pkg::DATA_W-1:0] m_data_i,
  output logic                       irq_o
);
  import soc_pkg::*;

  dma_state_t        state_q;
  logic [DATA_W-1:0] src_q;
  logic [DATA_W-1:0] dst_q;
  logic [DATA_W-1:0] len_q;
  logic [DATA_W-1:0] idx_q;
  logic [DATA_W-1:0] hold_q;
  logic [DATA_W-1:0] rdata_q;
  logic              cyc_q;
  logic              irq_q;
  logic              ack_q;
  logic              access;
  logic              wr_ctrl;
  logic              start;
  logic              busy;

  assign access  = s_cyc_i && !ack_q;
  assign wr_ctrl = access && s_we_i && (s_addr_i[3:0] == DMA_CTRL) && s_strb_i[0];
  assign busy    = (state_q != DMA_IDLE);
  // Start while busy is dropped
  assign start   = wr_ctrl && s_data_i[0] && !busy;

  ////////////////////////////////////////
  // Register slave
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      src_q <= '0;
      dst_q <= '0;
      len_q <= '0;
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
      if (access && s_we_i) begin
        case (s_addr_i[3:0])
          DMA_SRC: src_q <= apply_strb(src_q, s_data_i, s_strb_i);
          DMA_DST: dst_q <= apply_strb(dst_q, s_data_i, s_strb_i);
          DMA_LEN: len_q <= apply_strb(len_q, s_data_i, s_strb_i);
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      case (s_addr_i[3:0])
        DMA_SRC:  rdata_q <= src_q;
        DMA_DST:  rdata_q <= dst_q;
        DMA_LEN:  rdata_q <= len_q;
        default:  rdata_q <= {{(DATA_W-2){1'b0}}, irq_q, busy};
      endcase
    end
  end

  ////////////////////////////////////////
  // Copy FSM
  ////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= DMA_IDLE;
      cyc_q   <= 1'b0;
      idx_q   <= '0;
    end else begin
      case (state_q)
        DMA_IDLE: begin
          if (start) begin
            idx_q   <= '0;
            state_q <= (len_q == '0) ? DMA_DONE : DMA_READ;
          end
        end
        DMA_READ: begin
          // cyc rises a cycle after entry, giving the bus an idle gap
          if (!cyc_q) begin
            cyc_q <= 1'b1;
          end else if (m_ack_i) begin
            cyc_q   <= 1'b0;
            state_q <= DMA_WRITE;
          end
        end
        DMA_WRITE: begin
          if (!cyc_q) begin
            cyc_q <= 1'b1;
          end else if (m_ack_i) begin
            cyc_q <= 1'b0;
            if (idx_q == len_q - 1'b1) begin
              state_q <= DMA_DONE;
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= DMA_READ;
            end
          end
        end
        default: state_q <= DMA_IDLE;
      endcase
    end
  end

  // Word in flight between the read and the write
  always_ff @(posedge clk) begin
    if (state_q == DMA_READ && cyc_q && m_ack_i) hold_q <= m_data_i;
  end

  // Pending interrupt, set on completion
  always_ff @(posedge clk) begin
    if (rst_i) begin
      irq_q <= 1'b0;
    end else if (state_q == DMA_DONE) begin
      irq_q <= 1'b1;
    end else if (wr_ctrl && s_data_i[1]) begin
      irq_q <= 1'b0;
    end
  end

  assign m_cyc_o  = cyc_q;
  assign m_we_o   = (state_q == DMA_WRITE);
  assign m_strb_o = {STRB_W{1'b1}};
  assign m_addr_o = ((state_q == DMA_WRITE) ? dst_q : src_q) + {idx_q[ADDR_W-3:0], 2'b00};
  assign m_data_o = hold_q;
  assign s_ack_o  = ack_q;
  assign s_data_o = rdata_q;
  assign irq_o    = irq_q;

endmodule

/* hdl/system.sv */
// SoC top level: bus, main memory, keyboard and DMA engine.
// The CPU master port is brought out for an external driver.
`timescale 1ns/1ps
module system (
  input  logic                       clk,
  input  logic                       rst_i,
  // CPU master port
  input  logic                       m_cyc_i,
  input  logic                       m_we_i,
  input  logic [soc_pkg::STRB_W-1:0] m_strb_i,
  input  logic [soc_pkg::ADDR_W-1:0] m_addr_i,
  input  logic [soc_pkg::DATA_W-1:0] m_data_i,
  output logic                       m_ack_o,
  output logic [soc_pkg::DATA_W-1:0] m_data_o,
  // Scan-code input
  input  logic                       key_valid_i,
  input  logic [7:0]                 key_data_i,
  output logic                       key_ready_o,
  output logic                       irq_o
);
  import soc_pkg::*;

  // DMA master port
  logic              m_dma_cyc, m_dma_we, m_dma_ack;
  logic [STRB_W-1:0] m_dma_strb;
  logic [ADDR_W-1:0] m_dma_addr;
  logic [DATA_W-1:0] m_dma_wdata, m_dma_rdata;

  // Slave ports
  logic              s_mem_cyc, s_mem_we, s_mem_ack;
  logic [STRB_W-1:0] s_mem_strb;
  logic [ADDR_W-1:0] s_mem_addr;
  logic [DATA_W-1:0] s_mem_wdata, s_mem_rdata;

  logic              s_dma_cyc, s_dma_we, s_dma_ack;
  logic [STRB_W-1:0] s_dma_strb;
  logic [ADDR_W-1:0] s_dma_addr;
  logic [DATA_W-1:0] s_dma_wdata, s_dma_rdata;

  logic              s_key_cyc, s_key_we, s_key_ack;
  logic [STRB_W-1:0] s_key_strb;
  logic [ADDR_W-1:0] s_key_addr;
  logic [DATA_W-1:0] s_key_wdata, s_key_rdata;

  ////////////////////////////////////////
  // Bus
  ////////////////////////////////////////
  wish_bus u_wish_bus (
    .clk          (clk),
    .rst_i        (rst_i),
    .m_cpu_cyc_i  (m_cyc_i),      .m_cpu_we_i   (m_we_i),      .m_cpu_strb_i (m_strb_i),
    .m_cpu_addr_i (m_addr_i),     .m_cpu_data_i (m_data_i),
    .m_cpu_ack_o  (m_ack_o),      .m_cpu_data_o (m_data_o),
    .m_dma_cyc_i  (m_dma_cyc),    .m_dma_we_i   (m_dma_we),    .m_dma_strb_i (m_dma_strb),
    .m_dma_addr_i (m_dma_addr),   .m_dma_data_i (m_dma_wdata),
    .m_dma_ack_o  (m_dma_ack),    .m_dma_data_o (m_dma_rdata),
    .s_mem_cyc_o  (s_mem_cyc),    .s_mem_we_o   (s_mem_we),    .s_mem_strb_o (s_mem_strb),
    .s_mem_addr_o (s_mem_addr),   .s_mem_data_o (s_mem_wdata),
    .s_mem_ack_i  (s_mem_ack),    .s_mem_data_i (s_mem_rdata),
    .s_dma_cyc_o  (s_dma_cyc),    .s_dma_we_o   (s_dma_we),    .s_dma_strb_o (s_dma_strb),
    .s_dma_addr_o (s_dma_addr),   .s_dma_data_o (s_dma_wdata),
    .s_dma_ack_i  (s_dma_ack),    .s_dma_data_i (s_dma_rdata),
    .s_key_cyc_o  (s_key_cyc),    .s_key_we_o   (s_key_we),    .s_key_strb_o (s_key_strb),
    .s_key_addr_o (s_key_addr),   .s_key_data_o (s_key_wdata),
    .s_key_ack_i  (s_key_ack),    .s_key_data_i (s_key_rdata)
  );

  ////////////////////////////////////////
  // Slaves and DMA
  ////////////////////////////////////////
  main_mem u_main_mem (
    .clk      (clk),         .rst_i    (rst_i),
    .s_cyc_i  (s_mem_cyc),   .s_we_i   (s_mem_we),    .s_strb_i (s_mem_strb),
    .s_addr_i (s_mem_addr),  .s_data_i (s_mem_wdata),
    .s_ack_o  (s_mem_ack),   .s_data_o (s_mem_rdata)
  );

  keyboard u_keyboard (
    .clk         (clk),          .rst_i      (rst_i),
    .key_valid_i (key_valid_i),  .key_data_i (key_data_i), .key_ready_o (key_ready_o),
    .s_cyc_i     (s_key_cyc),    .s_we_i     (s_key_we),   .s_strb_i    (s_key_strb),
    .s_addr_i    (s_key_addr),   .s_data_i   (s_key_wdata),
    .s_ack_o     (s_key_ack),    .s_data_o   (s_key_rdata)
  );

  dma_ctrl u_dma_ctrl (
    .clk      (clk),          .rst_i    (rst_i),
    .s_cyc_i  (s_dma_cyc),    .s_we_i   (s_dma_we),    .s_strb_i (s_dma_strb),
    .s_addr_i (s_dma_addr),   .s_data_i (s_dma_wdata),
    .s_ack_o  (s_dma_ack),    .s_data_o (s_dma_rdata),
    .m_cyc_o  (m_dma_cyc),    .m_we_o   (m_dma_we),    .m_strb_o (m_dma_strb),
    .m_addr_o (m_dma_addr),   .m_data_o (m_dma_wdata),
    .m_ack_i  (m_dma_ack),    .m_data_i (m_dma_rdata),
    .irq_o    (irq_o)
  );

endmodule

/* bench/tb_system.sv */
// Testbench for the SoC top level. Drives the CPU master port and the
// scan-code input, keeps a reference copy of main memory, and checks
// memory access, unmapped decode, the keyboard FIFO, DMA copy and IRQ,
// and bus sharing between the CPU port and the DMA engine.
`timescale 1ns/1ps
module tb_system;
  import soc_pkg::*;

  localparam int BUS_TIMEOUT = 50;
  localparam int IRQ_TIMEOUT = 5000;
  localparam int KEY_TIMEOUT = 20;

  logic              clk;
  logic              rst_i;
  logic              m_cyc;
  logic              m_we;
  logic [STRB_W-1:0] m_strb;
  logic [ADDR_W-1:0] m_addr;
  logic [DATA_W-1:0] m_data;
  logic              m_ack;
  logic [DATA_W-1:0] m_rdata;
  logic              key_valid;
  logic [7:0]        key_data;
  logic              key_ready;
  logic              irq;

  logic [DATA_W-1:0] model [MEM_WORDS];
  logic [7:0]        codes [$];
  logic              hung = 1'b0;
  int                seed;
  int                checks;
  int                errors;
  int                test_no;
  int                errors_at_start;
  grant_t            other_master;

  system u_dut (
    .clk         (clk),        .rst_i       (rst_i),
    .m_cyc_i     (m_cyc),      .m_we_i      (m_we),      .m_strb_i    (m_strb),
    .m_addr_i    (m_addr),     .m_data_i    (m_data),
    .m_ack_o     (m_ack),      .m_data_o    (m_rdata),
    .key_valid_i (key_valid),  .key_data_i  (key_data),  .key_ready_o (key_ready),
    .irq_o       (irq)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Ends the run once a wait has given up
  initial begin
    wait (hung);
    $display("RESULT: FAIL");
    $finish;
  end

  ////////////////////////////////////////
  // Address and data helpers
  ////////////////////////////////////////
  function automatic logic [ADDR_W-1:0] mem_addr(input int idx);
    return {REGION_MEM, 18'b0, idx[7:0], 2'b00};
  endfunction

  function automatic logic [ADDR_W-1:0] reg_addr(input logic [3:0] region,
                                                 input logic [3:0] off);
    return {region, 24'b0, off};
  endfunction

  // Fill value tied to every bit of the word index
  function automatic logic [DATA_W-1:0] fill_word(input int idx);
    logic [7:0] w;
    w = idx[7:0];
    return {w ^ 8'hA5, 8'h3C, ~w, w};
  endfunction

  function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_w,
                                                    input logic [DATA_W-1:0] new_w,
                                                    input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  ////////////////////////////////////////
  // Checking and bookkeeping
  ////////////////////////////////////////
  task automatic check_eq(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                          input string what);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERROR at %0d ns: %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic start_test();
    test_no++;
    errors_at_start = errors;
  endtask

  task automatic finish_test(input string name);
    $display("test %0d %s: %s", test_no, name, (errors == errors_at_start) ? "ok" : "failed");
  endtask

  // Blocks this process for good; the watchdog above closes the run
  task automatic give_up(input string why);
    $display("Stopped: %s", why);
    hung = 1'b1;
    forever @(posedge clk);
  endtask

  ////////////////////////////////////////
  // Bus and scan-code stimulus
  ////////////////////////////////////////
  task automatic wait_ack(input string what);
    int n;
    n = 0;
    while (!m_ack) begin
      if (n == BUS_TIMEOUT) give_up($sformatf("the bus never acknowledged the %s", what));
      @(posedge clk);
      #1;
      n++;
    end
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [STRB_W-1:0] strb);
    m_cyc  = 1'b1;
    m_we   = 1'b1;
    m_addr = addr;
    m_data = data;
    m_strb = strb;
    wait_ack($sformatf("write to %h", addr));
    m_cyc = 1'b0;
    m_we  = 1'b0;
    // Idle cycle between accesses
    @(posedge clk);
    #1;
  endtask

  task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    m_cyc  = 1'b1;
    m_we   = 1'b0;
    m_addr = addr;
    m_strb = 4'hF;
    wait_ack($sformatf("read from %h", addr));
    data  = m_rdata;
    m_cyc = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic push_code(input logic [7:0] code);
    int n;
    n = 0;
    key_valid = 1'b1;
    key_data  = code;
    while (!key_ready) begin
      if (n == KEY_TIMEOUT) give_up("the keyboard never became ready for a scan code");
      @(posedge clk);
      #1;
      n++;
    end
    @(posedge clk);
    #1;
    key_valid = 1'b0;
  endtask

  task automatic pop_code();
    logic [DATA_W-1:0] got;
    logic [7:0]        exp_code;
    exp_code = codes.pop_front();
    bus_read(reg_addr(REGION_KEY, KEY_DATA), got);
    check_eq(got, {23'b0, 1'b1, exp_code}, "popped scan code");
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    while (!irq) begin
      if (n == IRQ_TIMEOUT) give_up("the DMA copy never raised its interrupt");
      @(posedge clk);
      #1;
      n++;
    end
  endtask

  task automatic start_copy(input int src_idx, input int dst_idx, input int len);
    bus_write(reg_addr(REGION_DMA, DMA_SRC), mem_addr(src_idx), 4'hF);
    bus_write(reg_addr(REGION_DMA, DMA_DST), mem_addr(dst_idx), 4'hF);
    bus_write(reg_addr(REGION_DMA, DMA_LEN), 32'(len), 4'hF);
    bus_write(reg_addr(REGION_DMA, DMA_CTRL), 32'h1, 4'hF);
  endtask

  task automatic verify_memory(input string what);
    logic [DATA_W-1:0] d;
    for (int i = 0; i < MEM_WORDS; i++) begin
      bus_read(mem_addr(i), d);
      check_eq(d, model[i], $sformatf("%s %0d", what, i));
    end
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////
  initial begin
    logic [DATA_W-1:0] d;
    logic [STRB_W-1:0] s;
    int                taken;
    seed      = 43371;
    checks    = 0;
    errors    = 0;
    test_no   = 0;
    rst_i     = 1'b1;
    m_cyc     = 1'b0;
    m_we      = 1'b0;
    m_strb    = '0;
    m_addr    = '0;
    m_data    = '0;
    key_valid = 1'b0;
    key_data  = '0;
    repeat (5) @(posedge clk);
    #1;
    rst_i = 1'b0;

    // Full fill, random words, then partial strobes
    start_test();
    check_eq(32'(irq), 32'd0, "irq_o after reset");
    check_eq(32'(key_ready), 32'd1, "key_ready_o after reset");
    check_eq(32'(m_ack), 32'd0, "m_ack_o after reset");
    for (int i = 0; i < MEM_WORDS; i++) begin
      model[i] = fill_word(i);
      bus_write(mem_addr(i), model[i], 4'hF);
    end
    for (int i = 0; i < 16; i++) begin
      d        = $random(seed);
      model[i] = d;
      bus_write(mem_addr(i), d, 4'hF);
    end
    for (int i = 16; i < 24; i++) begin
      d        = $random(seed);
      s        = 4'($random(seed));
      model[i] = merge_bytes(model[i], d, s);
      bus_write(mem_addr(i), d, s);
    end
    verify_memory("memory word");
    finish_test("memory write and read");

    start_test();
    bus_read({4'hF, 28'h10}, d);
    check_eq(d, BUS_DEFAULT_DATA, "unmapped read data");
    finish_test("unmapped region");

    start_test();
    codes.delete();
    for (int i = 0; i < 5; i++) begin
      codes.push_back(8'($random(seed)));
      push_code(codes[i]);
    end
    bus_read(reg_addr(REGION_KEY, KEY_COUNT), d);
    check_eq(d, 32'd5, "keyboard count after five codes");
    repeat (5) pop_code();
    // Ten offered codes, the last two meet a full FIFO
    taken = 0;
    for (int i = 0; i < 10; i++) begin
      key_valid = 1'b1;
      key_data  = 8'h40 + 8'(i);
      if (key_ready) begin
        codes.push_back(key_data);
        taken++;
      end
      @(posedge clk);
      #1;
    end
    key_valid = 1'b0;
    check_eq(32'(taken), 32'd8, "codes accepted before back-pressure");
    check_eq(32'(key_ready), 32'd0, "key_ready_o with a full FIFO");
    bus_read(reg_addr(REGION_KEY, KEY_COUNT), d);
    check_eq(d, 32'd8, "keyboard count when full");
    repeat (8) pop_code();
    bus_read(reg_addr(REGION_KEY, KEY_DATA), d);
    check_eq(d, 32'd0, "pop from an empty FIFO");
    finish_test("keyboard FIFO");

    start_test();
    for (int i = 32; i < 48; i++) begin
      model[i] = $random(seed);
      bus_write(mem_addr(i), model[i], 4'hF);
    end
    start_copy(32, 64, 16);
    wait_irq();
    for (int i = 0; i < 16; i++) begin
      model[64 + i] = model[32 + i];
    end
    verify_memory("memory after copy");
    finish_test("DMA copy");

    start_test();
    bus_read(reg_addr(REGION_DMA, DMA_CTRL), d);
    check_eq(d, 32'h2, "DMA_CTRL after copy");
    bus_write(reg_addr(REGION_DMA, DMA_CTRL), 32'h2, 4'hF);
    check_eq(32'(irq), 32'd0, "irq_o after clear");
    bus_read(reg_addr(REGION_DMA, DMA_CTRL), d);
    check_eq(d, 32'h0, "DMA_CTRL after clear");
    finish_test("interrupt and busy");

    // CPU reads words 200 to 239 while words 96 to 111 move to 128
    start_test();
    other_master = GNT_DMA;
    for (int i = 96; i < 112; i++) begin
      model[i] = $random(seed);
      bus_write(mem_addr(i), model[i], 4'hF);
    end
    start_copy(96, 128, 16);
    bus_read(reg_addr(REGION_DMA, DMA_CTRL), d);
    check_eq({31'b0, d[0]}, 32'd1, "busy bit during copy");
    for (int i = 200; i < 240; i++) begin
      bus_read(mem_addr(i), d);
      check_eq(d, model[i], $sformatf("CPU read during copy %0d", i));
    end
    wait_irq();
    bus_write(reg_addr(REGION_DMA, DMA_CTRL), 32'h2, 4'hF);
    for (int i = 0; i < 16; i++) begin
      model[128 + i] = model[96 + i];
    end
    verify_memory("memory after shared copy");
    finish_test($sformatf("bus shared with %s", other_master.name()));

    $display("Finished %0d tests: %0d checks, %0d errors", test_no, checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* src.f */
common/soc_pkg.sv
hdl/wish_bus.sv
hdl/main_mem.sv
keyboard/keyboard.sv
disk/dma_ctrl.sv
hdl/system.sv
bench/tb_system.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and scan the log for failure
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_system -o tb_system \
  && ./obj_dir/tb_system > sim.log 2>&1 \
  || { echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "Simulation reported failure"; exit 1; } || exit 0
